// ==== src.f ====
+incdir+tb
logic/dbg_pkg.sv
logic/uart_word_reader.sv
logic/frame_writer.sv
logic/report_builder.sv
logic/session_controller.sv
logic/dbg_top.sv
tb/tb_dbg_top.sv

// ==== Makefile ====
# Verilator simulation of the debug controller testbench.
# Every variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= tb_dbg_top
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
PASS_TEXT ?= TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/dbg_ref.svh ====
`ifndef DBG_REF_SVH
`define DBG_REF_SVH

localparam logic [7:0]  REF_INFO           = 8'h49; // ascii I.
localparam logic [7:0]  REF_ERROR          = 8'h45; // ascii E.
localparam logic [7:0]  REF_NONE           = 8'hFF; // empty cycle or address field.
localparam logic [31:0] REF_ERR_UNKNOWN    = 32'd1;
localparam logic [31:0] REF_ERR_LOADED     = 32'd2;
localparam logic [31:0] REF_ERR_FULL       = 32'd3;
localparam logic [31:0] REF_ERR_NO_PROGRAM = 32'd4;
localparam logic [31:0] REF_INFO_END       = 32'd1;
localparam logic [31:0] LFSR_TAPS          = 32'hA3000000; // taps 32, 30, 26 and 25.

// byte i of a reply sits in bits 8i+7 down to 8i, so bits 7:0 leave first.
function automatic logic [55:0] frame_bytes(input logic [7:0] prefix, input logic [7:0] cycle,
                                            input logic [7:0] address, input logic [31:0] data);
    logic [55:0] bytes;
    bytes[31:0]  = data;
    bytes[39:32] = address;
    bytes[47:40] = cycle;
    bytes[55:48] = prefix;
    return bytes;
endfunction

function automatic logic [31:0] reg_value(input int r, input int count);
    logic [31:0] value;
    value[31:24] = 8'hA0 ^ 8'(r);
    value[23:16] = 8'(count);
    value[15:0]  = 16'(r * 977 + count * 131) ^ 16'h5A5A; // mixes both so no two collide.
    return value;
endfunction

function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic [31:0] next;
    if (state[0])
        next = (state >> 1) ^ LFSR_TAPS;
    else
        next = state >> 1;
    return next;
endfunction

`endif

// ==== tb/tb_dbg_top.sv ====
module tb_dbg_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_REGS       = 8;
    localparam int IMEM_DEPTH     = 16;
    localparam int END_COUNT      = 5;
    localparam int EXPECTED_BYTES = 7 * (4 + (NUM_REGS + 1) + 3 * NUM_REGS);
    localparam int TIMEOUT_CYCLES = EXPECTED_BYTES * 8 + 2000;

    `include "dbg_ref.svh"

    logic                              i_clk;
    logic                              i_reset;
    logic                              i_uart_empty;
    logic [7:0]                        i_uart_data;
    logic                              i_uart_full;
    logic                              i_imem_empty;
    logic                              i_imem_full;
    logic                              i_mips_end_program;
    dbg_pkg::word_t [NUM_REGS - 1 : 0] i_registers;
    logic                              o_uart_rd;
    logic                              o_uart_wr;
    logic [7:0]                        o_uart_data;
    dbg_pkg::imem_wr_t                 o_imem_wr;
    logic                              o_mips_start;
    logic                              o_mips_enabled;

    logic [7:0]  rx_queue[$];
    logic        rx_pop;
    logic [7:0]  expected_bytes[$];
    logic [31:0] lfsr_state;
    logic        backpressure;
    logic [31:0] imem[IMEM_DEPTH];
    int          imem_count;
    logic        force_full;
    int          core_count;
    int          start_count;
    int          cycle_count;
    logic [31:0] program_words[4];

    dbg_top #(.NUM_REGS(NUM_REGS)) dbg_top_inst
    (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .i_uart_empty       (i_uart_empty),
        .i_uart_data        (i_uart_data),
        .i_uart_full        (i_uart_full),
        .i_imem_empty       (i_imem_empty),
        .i_imem_full        (i_imem_full),
        .i_mips_end_program (i_mips_end_program),
        .i_registers        (i_registers),
        .o_uart_rd          (o_uart_rd),
        .o_uart_wr          (o_uart_wr),
        .o_uart_data        (o_uart_data),
        .o_imem_wr          (o_imem_wr),
        .o_mips_start       (o_mips_start),
        .o_mips_enabled     (o_mips_enabled)
    );

    always #4 i_clk = ~i_clk;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
            fail_run($sformatf("mismatch at %0t: %s is %h, expected %h",
                               $time, name, got, expected));
    endtask

    function automatic logic take_bit();
        logic b;
        b          = lfsr_state[0];
        lfsr_state = lfsr_step(lfsr_state);
        return b;
    endfunction

    task automatic push_word(input logic [31:0] w);
        @(posedge i_clk);
        for (int i = 0; i < 4; i++)
            rx_queue.push_back(w[8 * i +: 8]); // low byte goes first.
    endtask

    task automatic send_command(input logic [7:0] letter);
        push_word({24'd0, letter});
    endtask

    task automatic expect_frame(input logic [7:0] prefix, input logic [7:0] cycle,
                                input logic [7:0] address, input logic [31:0] data);
        logic [55:0] bytes;
        bytes = frame_bytes(prefix, cycle, address, data);
        for (int i = 0; i < 7; i++)
            expected_bytes.push_back(bytes[8 * i +: 8]);
    endtask

    task automatic expect_dump(input logic [7:0] cycle, input int count);
        for (int r = 0; r < NUM_REGS; r++)
            expect_frame(REF_INFO, cycle, 8'(r), reg_value(r, count));
    endtask

    task automatic wait_idle();
        while (rx_queue.size() != 0 || expected_bytes.size() != 0)
            @(posedge i_clk);
        repeat (40) @(posedge i_clk); // room for a stray byte to show up.
    endtask

    // host side of the receive FIFO; a read is taken off the queue one cycle later.
    always @(negedge i_clk)
    begin
        if (rx_pop && rx_queue.size() != 0)
            void'(rx_queue.pop_front());
        rx_pop = !i_reset && o_uart_rd;
        i_uart_empty <= (rx_queue.size() == 0);
        i_uart_data  <= (rx_queue.size() != 0) ? rx_queue[0] : 8'h00;
    end

    always @(negedge i_clk)
    begin
        if (backpressure)
            i_uart_full <= take_bit();
        else
            i_uart_full <= 1'b0;
    end

    always @(negedge i_clk)
    begin
        if (!i_reset && o_imem_wr.valid)
        begin
            if (imem_count < IMEM_DEPTH)
                imem[imem_count] = o_imem_wr.instr;
            imem_count = imem_count + 1;
        end
        i_imem_empty <= (imem_count == 0);
        i_imem_full  <= force_full || (imem_count >= IMEM_DEPTH);
    end

    // the core counts enabled cycles from each start and halts at END_COUNT.
    always @(negedge i_clk)
    begin
        if (!i_reset)
        begin
            if (o_mips_start)
            begin
                core_count  = 0;
                start_count = start_count + 1;
            end
            if (o_mips_enabled && core_count < END_COUNT)
                core_count = core_count + 1;
            i_mips_end_program <= (core_count == END_COUNT);
            for (int r = 0; r < NUM_REGS; r++)
                i_registers[r] <= reg_value(r, core_count);
        end
    end

    always @(negedge i_clk)
    begin
        if (!i_reset && o_uart_wr)
        begin
            if (expected_bytes.size() == 0)
                fail_run($sformatf("byte %h was written to the UART at %0t with no reply due",
                                   o_uart_data, $time));
            else
                check_value("o_uart_data", o_uart_data, expected_bytes.pop_front());
        end
    end

    always @(posedge i_clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES)
            fail_run($sformatf("the run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end

    initial
    begin
        i_clk              = 1'b0;
        i_reset            = 1'b1;
        i_uart_empty       = 1'b1;
        i_uart_data        = 8'h00;
        i_uart_full        = 1'b0;
        i_imem_empty       = 1'b1;
        i_imem_full        = 1'b0;
        i_mips_end_program = 1'b0;
        for (int r = 0; r < NUM_REGS; r++)
            i_registers[r] = reg_value(r, 0);
        rx_pop           = 1'b0;
        lfsr_state       = 32'h3cc4f63e;
        backpressure     = 1'b0;
        imem_count       = 0;
        force_full       = 1'b0;
        core_count       = 0;
        start_count      = 0;
        cycle_count      = 0;
        program_words[0] = 32'h20080005;
        program_words[1] = 32'h2009000A;
        program_words[2] = 32'h01095020;
        program_words[3] = dbg_pkg::HALT_WORD;

        repeat (10) @(negedge i_clk);
        i_reset <= 1'b0;

        repeat (8)
        begin
            @(negedge i_clk);
            check_value("o_uart_rd", o_uart_rd, 0);
            check_value("o_uart_wr", o_uart_wr, 0);
            check_value("o_imem_wr.valid", o_imem_wr.valid, 0);
            check_value("o_mips_start", o_mips_start, 0);
            check_value("o_mips_enabled", o_mips_enabled, 0);
        end

        expect_frame(REF_ERROR, REF_NONE, REF_NONE, REF_ERR_UNKNOWN);
        send_command("X");
        wait_idle();
        expect_frame(REF_ERROR, REF_NONE, REF_NONE, REF_ERR_NO_PROGRAM);
        send_command(dbg_pkg::CMD_RUN);
        wait_idle();

        send_command(dbg_pkg::CMD_LOAD);
        for (int i = 0; i < 4; i++)
            push_word(program_words[i]);
        wait_idle();
        check_value("imem write count", imem_count, 4);
        for (int i = 0; i < 4; i++)
            check_value($sformatf("imem[%0d]", i), imem[i], program_words[i]);

        expect_frame(REF_ERROR, REF_NONE, REF_NONE, REF_ERR_LOADED);
        send_command(dbg_pkg::CMD_LOAD);
        wait_idle();
        force_full = 1'b1;
        expect_frame(REF_ERROR, REF_NONE, REF_NONE, REF_ERR_FULL);
        send_command(dbg_pkg::CMD_LOAD);
        wait_idle();
        force_full = 1'b0;
        check_value("imem write count", imem_count, 4);

        backpressure = 1'b1;
        expect_dump(REF_NONE, END_COUNT);
        expect_frame(REF_INFO, REF_NONE, REF_NONE, REF_INFO_END);
        send_command(dbg_pkg::CMD_RUN);
        wait_idle();

        expect_dump(8'd1, 1); // S itself performs the first step.
        send_command(dbg_pkg::CMD_STEP);
        wait_idle();
        expect_dump(8'd2, 2);
        send_command(dbg_pkg::CMD_NEXT);
        wait_idle();
        expect_dump(8'd3, 3);
        send_command(dbg_pkg::CMD_NEXT);
        wait_idle();
        send_command(dbg_pkg::CMD_STEP);
        wait_idle();

        check_value("start pulse count", start_count, 2);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== logic/dbg_top.sv ====
module dbg_top
#(
    parameter int NUM_REGS = 8
)
(
    input  logic                              i_clk,
    input  logic                              i_reset,
    input  logic                              i_uart_empty,
    input  logic [7:0]                        i_uart_data,
    input  logic                              i_uart_full,
    input  logic                              i_imem_empty,
    input  logic                              i_imem_full,
    input  logic                              i_mips_end_program,
    input  dbg_pkg::word_t [NUM_REGS - 1 : 0] i_registers,
    output logic                              o_uart_rd,
    output logic                              o_uart_wr,
    output logic [7:0]                        o_uart_data,
    output dbg_pkg::imem_wr_t                 o_imem_wr,
    output logic                              o_mips_start,
    output logic                              o_mips_enabled
);

    logic                 word_valid;
    logic                 word_ready;
    dbg_pkg::word_t       word;
    dbg_pkg::report_req_t req;
    logic                 report_done;
    dbg_pkg::frame_t      frame;
    logic                 frame_valid;
    logic                 frame_ready;

    uart_word_reader uart_word_reader_inst
    (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_uart_empty (i_uart_empty),
        .i_uart_data  (i_uart_data),
        .i_word_ready (word_ready),
        .o_uart_rd    (o_uart_rd),
        .o_word_valid (word_valid),
        .o_word       (word)
    );

    session_controller session_controller_inst
    (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .i_word_valid       (word_valid),
        .i_word             (word),
        .i_report_done      (report_done),
        .i_imem_empty       (i_imem_empty),
        .i_imem_full        (i_imem_full),
        .i_mips_end_program (i_mips_end_program),
        .o_word_ready       (word_ready),
        .o_req              (req),
        .o_imem_wr          (o_imem_wr),
        .o_mips_start       (o_mips_start),
        .o_mips_enabled     (o_mips_enabled)
    );

    report_builder #(.NUM_REGS(NUM_REGS)) report_builder_inst
    (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_req         (req),
        .i_registers   (i_registers),
        .i_frame_ready (frame_ready),
        .o_frame       (frame),
        .o_frame_valid (frame_valid),
        .o_report_done (report_done)
    );

    frame_writer frame_writer_inst
    (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_frame       (frame),
        .i_frame_valid (frame_valid),
        .i_uart_full   (i_uart_full),
        .o_frame_ready (frame_ready),
        .o_uart_wr     (o_uart_wr),
        .o_uart_data   (o_uart_data)
    );

endmodule

// ==== logic/session_controller.sv ====
module session_controller
(
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_word_valid,
    input  dbg_pkg::word_t       i_word,
    input  logic                 i_report_done,
    input  logic                 i_imem_empty,
    input  logic                 i_imem_full,
    input  logic                 i_mips_end_program,
    output logic                 o_word_ready,
    output dbg_pkg::report_req_t o_req,
    output dbg_pkg::imem_wr_t    o_imem_wr,
    output logic                 o_mips_start,
    output logic                 o_mips_enabled
);

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        RUN,
        STEP_WAIT,
        DUMP,
        REPORT
    } state_t;

    state_t     state;
    state_t     ret_state; // RUN here means the end frame is still owed.
    logic [7:0] step_cnt;

    function automatic dbg_pkg::report_req_t message(input logic [7:0] prefix,
                                                     input dbg_pkg::word_t code);
        dbg_pkg::report_req_t req;
        req.valid  = 1'b1;
        req.kind   = dbg_pkg::MESSAGE;
        req.prefix = prefix;
        req.code   = code;
        req.cycle  = dbg_pkg::NO_CYCLE;
        return req;
    endfunction

    assign o_word_ready = (state == IDLE) || (state == LOAD) ||
                          ((state == STEP_WAIT) && !i_mips_end_program);

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            state          <= IDLE;
            ret_state      <= IDLE;
            step_cnt       <= 8'd0;
            o_req          <= '0;
            o_imem_wr      <= '0;
            o_mips_start   <= 1'b0;
            o_mips_enabled <= 1'b0;
        end
        else
        begin
            o_imem_wr.valid <= 1'b0;
            o_mips_start    <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (i_word_valid)
                    begin
                        ret_state <= IDLE;
                        state     <= REPORT;
                        case (i_word)
                            {24'd0, dbg_pkg::CMD_LOAD}:
                            begin
                                if (i_imem_full)
                                    o_req <= message(dbg_pkg::PREFIX_ERROR, dbg_pkg::ERR_IMEM_FULL);
                                else if (!i_imem_empty)
                                    o_req <= message(dbg_pkg::PREFIX_ERROR,
                                                     dbg_pkg::ERR_ALREADY_LOADED);
                                else
                                    state <= LOAD;
                            end
                            {24'd0, dbg_pkg::CMD_RUN}, {24'd0, dbg_pkg::CMD_STEP}:
                            begin
                                if (i_imem_empty)
                                    o_req <= message(dbg_pkg::PREFIX_ERROR, dbg_pkg::ERR_NO_PROGRAM);
                                else
                                begin
                                    o_mips_start   <= 1'b1;
                                    o_mips_enabled <= 1'b1;
                                    step_cnt       <= 8'd1;
                                    if (i_word[7:0] == dbg_pkg::CMD_RUN)
                                    begin
                                        ret_state <= RUN;
                                        state     <= RUN;
                                    end
                                    else
                                    begin
                                        ret_state <= STEP_WAIT;
                                        state     <= DUMP; // S performs the first step itself.
                                    end
                                end
                            end
                            default:
                                o_req <= message(dbg_pkg::PREFIX_ERROR,
                                                 dbg_pkg::ERR_UNKNOWN_COMMAND);
                        endcase
                    end
                end
                LOAD:
                begin
                    if (i_word_valid)
                    begin
                        o_imem_wr.valid <= 1'b1;
                        o_imem_wr.instr <= i_word;
                        if (i_word == dbg_pkg::HALT_WORD)
                            state <= IDLE;
                    end
                end
                RUN:
                begin
                    if (i_mips_end_program && !o_mips_start) // ignore a stale flag at start.
                    begin
                        o_mips_enabled <= 1'b0;
                        state          <= DUMP;
                    end
                end
                STEP_WAIT:
                begin
                    if (i_mips_end_program)
                    begin
                        o_req     <= message(dbg_pkg::PREFIX_INFO, dbg_pkg::INFO_END_PROGRAM);
                        ret_state <= IDLE;
                        state     <= REPORT;
                    end
                    else if (i_word_valid)
                    begin
                        if (i_word == {24'd0, dbg_pkg::CMD_NEXT})
                        begin
                            step_cnt       <= step_cnt + 8'd1;
                            o_mips_enabled <= 1'b1;
                            state          <= DUMP;
                        end
                        else if (i_word == {24'd0, dbg_pkg::CMD_STEP})
                            state <= IDLE;
                        else
                        begin
                            o_req     <= message(dbg_pkg::PREFIX_ERROR,
                                                 dbg_pkg::ERR_UNKNOWN_COMMAND);
                            ret_state <= IDLE;
                            state     <= REPORT;
                        end
                    end
                end
                DUMP:
                begin
                    o_mips_enabled <= 1'b0;
                    o_req.valid    <= 1'b1;
                    o_req.kind     <= dbg_pkg::REG_DUMP;
                    o_req.prefix   <= dbg_pkg::PREFIX_INFO;
                    o_req.code     <= '0;
                    o_req.cycle    <= (ret_state == STEP_WAIT) ? step_cnt : dbg_pkg::NO_CYCLE;
                    state          <= REPORT;
                end
                REPORT:
                begin
                    if (o_req.valid)
                    begin
                        if (i_report_done)
                            o_req.valid <= 1'b0;
                    end
                    else if (ret_state == RUN)
                    begin
                        o_req     <= message(dbg_pkg::PREFIX_INFO, dbg_pkg::INFO_END_PROGRAM);
                        ret_state <= IDLE;
                    end
                    else
                        state <= ret_state;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

endmodule

// ==== logic/report_builder.sv ====
module report_builder
#(
    parameter int NUM_REGS = 8
)
(
    input  logic                                i_clk,
    input  logic                                i_reset,
    input  dbg_pkg::report_req_t                i_req,
    input  dbg_pkg::word_t [NUM_REGS - 1 : 0]   i_registers,
    input  logic                                i_frame_ready,
    output dbg_pkg::frame_t                     o_frame,
    output logic                                o_frame_valid,
    output logic                                o_report_done
);

    localparam int               IDX_W    = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_REGS - 1);

    logic [IDX_W-1:0] reg_idx;
    logic             done_q;
    logic             handshake;
    logic             last_frame;

    assign o_frame_valid = i_req.valid && !done_q; // the request is still up while done shows.
    assign handshake     = o_frame_valid && i_frame_ready;
    assign last_frame    = (i_req.kind == dbg_pkg::MESSAGE) || (reg_idx == LAST_IDX);
    assign o_report_done = done_q;

    always_comb
    begin
        o_frame.cycle = i_req.cycle;
        if (i_req.kind == dbg_pkg::MESSAGE)
        begin
            o_frame.prefix  = i_req.prefix;
            o_frame.address = dbg_pkg::NO_ADDRESS;
            o_frame.data    = i_req.code;
        end
        else
        begin
            o_frame.prefix  = dbg_pkg::PREFIX_INFO;
            o_frame.address = 8'(reg_idx);
            o_frame.data    = i_registers[reg_idx]; // live value, taken at handover.
        end
    end

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            reg_idx <= '0;
            done_q  <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            if (handshake)
            begin
                if (last_frame)
                begin
                    reg_idx <= '0;
                    done_q  <= 1'b1;
                end
                else
                    reg_idx <= reg_idx + 1'b1;
            end
        end
    end

endmodule

// ==== logic/frame_writer.sv ====
module frame_writer
(
    input  logic            i_clk,
    input  logic            i_reset,
    input  dbg_pkg::frame_t i_frame,
    input  logic            i_frame_valid,
    input  logic            i_uart_full,
    output logic            o_frame_ready,
    output logic            o_uart_wr,
    output logic [7:0]      o_uart_data
);

    localparam logic [2:0] LAST_BYTE = 3'd6;

    dbg_pkg::frame_t frame_q;
    logic [2:0]      byte_ptr;
    logic            busy;
    logic            wr_q;
    logic [7:0]      data_q;
    logic            send;

    assign o_frame_ready = !busy;
    assign o_uart_wr     = wr_q;
    assign o_uart_data   = data_q;
    assign send          = busy && !wr_q && !i_uart_full; // the cycle after a pulse is a gap.

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            busy     <= 1'b0;
            byte_ptr <= 3'd0;
            wr_q     <= 1'b0;
        end
        else
        begin
            wr_q <= send;
            if (!busy && i_frame_valid)
            begin
                busy     <= 1'b1;
                byte_ptr <= 3'd0;
            end
            else if (send)
            begin
                if (byte_ptr == LAST_BYTE)
                    busy <= 1'b0;
                else
                    byte_ptr <= byte_ptr + 3'd1;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!busy && i_frame_valid)
            frame_q <= i_frame;
        if (send)
            data_q <= frame_q[{byte_ptr, 3'b000} +: 8];
    end

endmodule

// ==== logic/uart_word_reader.sv ====
module uart_word_reader
(
    input  logic           i_clk,
    input  logic           i_reset,
    input  logic           i_uart_empty,
    input  logic [7:0]     i_uart_data,
    input  logic           i_word_ready,
    output logic           o_uart_rd,
    output logic           o_word_valid,
    output dbg_pkg::word_t o_word
);

    logic [1:0]     byte_cnt;
    logic           rd_q;
    logic           valid_q;
    dbg_pkg::word_t word_q;

    assign o_uart_rd    = rd_q;
    assign o_word_valid = valid_q;
    assign o_word       = word_q;

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            byte_cnt <= 2'd0;
            rd_q     <= 1'b0;
            valid_q  <= 1'b0;
        end
        else
        begin
            rd_q <= 1'b0; // a read is never two cycles long.
            if (rd_q)
            begin
                byte_cnt <= byte_cnt + 2'd1;
                if (byte_cnt == 2'd3)
                    valid_q <= 1'b1;
            end
            else if (valid_q)
            begin
                if (i_word_ready)
                    valid_q <= 1'b0;
            end
            else if (!i_uart_empty)
                rd_q <= 1'b1;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (rd_q)
            word_q <= {i_uart_data, word_q[31:8]}; // the first byte ends in bits 7:0.
    end

endmodule

// ==== logic/dbg_pkg.sv ====
package dbg_pkg;

    typedef logic [31:0] word_t;

    typedef struct packed {
        logic [7:0] prefix;
        logic [7:0] cycle;
        logic [7:0] address;
        word_t      data; // sits at the low end so it leaves the UART first.
    } frame_t;

    typedef enum logic {
        MESSAGE,
        REG_DUMP
    } report_kind_t;

    typedef struct packed {
        logic         valid;
        report_kind_t kind;
        logic [7:0]   prefix;
        word_t        code;
        logic [7:0]   cycle;
    } report_req_t;

    typedef struct packed {
        logic  valid;
        word_t instr;
    } imem_wr_t;

    localparam logic [7:0] CMD_LOAD           = "L";
    localparam logic [7:0] CMD_RUN            = "E";
    localparam logic [7:0] CMD_STEP           = "S";
    localparam logic [7:0] CMD_NEXT           = "N";
    localparam logic [7:0] PREFIX_INFO        = "I";
    localparam logic [7:0] PREFIX_ERROR       = "E";
    localparam logic [7:0] NO_CYCLE           = 8'hFF;
    localparam logic [7:0] NO_ADDRESS         = 8'hFF;
    localparam word_t      ERR_UNKNOWN_COMMAND = 32'd1;
    localparam word_t      ERR_ALREADY_LOADED = 32'd2;
    localparam word_t      ERR_IMEM_FULL      = 32'd3;
    localparam word_t      ERR_NO_PROGRAM     = 32'd4;
    localparam word_t      INFO_END_PROGRAM   = 32'd1;
    localparam word_t      HALT_WORD          = 32'hFFFFFFFF; // last word of every program.

endpackage
